//--- rtl/cpuTypesPkg.sv
/*
 * CPU-side types for the memory system.
 * Words, addresses, RAM state and the port request/response structs.
 */
`default_nettype none

package cpuTypesPkg;

   // data path width
   localparam int unsigned WORD_WIDTH = 32;

   // load/store data word
   typedef logic [WORD_WIDTH-1:0] word;
   // word address as the CPU sees it
   typedef logic [WORD_WIDTH-1:0] wordAddress;

   // RAM progress as seen by the controller
   typedef enum logic [1:0] {
      FREE,
      BUSY,
      ACCESS
   } ramStateType;

   // fetch port
   typedef struct packed {
      logic       readEnable;
      wordAddress address;
   } instrRequest;

   // data port, enables and store word held until wait drops
   typedef struct packed {
      logic       readEnable;
      logic       writeEnable;
      wordAddress address;
      word        storeWord;
   } dataRequest;

   // returned to either port
   typedef struct packed {
      logic waitFlag;
      word  loadWord;
   } portResponse;

   // single request from controller into the RAM
   typedef struct packed {
      logic       readEnable;
      logic       writeEnable;
      wordAddress address;
      word        storeWord;
   } ramRequest;

endpackage

`default_nettype wire

//--- rtl/memConfigPkg.sv
/*
 * RAM bank configuration.
 * Depth, index width and access latency of the word RAM.
 */
`default_nettype none

package memConfigPkg;

   // number of words in the bank
   localparam int unsigned RAM_DEPTH = 256;

   // low address bits used as the RAM index
   // addresses above the depth wrap
   localparam int unsigned RAM_INDEX_WIDTH = $clog2(RAM_DEPTH);

   // busy cycles before the access cycle
   localparam int unsigned RAM_LATENCY = 2;

   // busy counter must hold RAM_LATENCY
   localparam int unsigned RAM_COUNT_WIDTH = $clog2(RAM_LATENCY + 1);

endpackage

`default_nettype wire

//--- rtl/memoryControl.sv
/*
 * Memory controller.
 * Arbitrates the fetch and data ports onto one RAM request.
 * Data wins over fetch. The winner's wait drops in the RAM access cycle.
 */
`default_nettype none

module memoryControl (
   input  cpuTypesPkg::instrRequest instrReq,
   input  cpuTypesPkg::dataRequest  dataReq,
   input  cpuTypesPkg::ramStateType ramState,
   input  cpuTypesPkg::word         ramLoad,
   output cpuTypesPkg::ramRequest   ramReq,
   output cpuTypesPkg::portResponse instrResp,
   output cpuTypesPkg::portResponse dataResp
);
   import cpuTypesPkg::*;

   // which port owns the RAM this cycle
   typedef enum logic [1:0] {
      GRANT_NONE,
      GRANT_INSTR,
      GRANT_DATA
   } grantType;

   grantType grant;
   logic     ramReady;

   // RAM has the word ready for the selected port
   assign ramReady = (ramState == ACCESS);

   // priority, data read or write first, then fetch
   always_comb begin
      if (dataReq.writeEnable || dataReq.readEnable) begin
         grant = GRANT_DATA;
      end else if (instrReq.readEnable) begin
         grant = GRANT_INSTR;
      end else begin
         grant = GRANT_NONE;
      end
   end

   // request mux toward the RAM
   always_comb begin
      // idle request is all zero
      ramReq = '0;
      case (grant)
         GRANT_DATA: begin
            ramReq.readEnable  = dataReq.readEnable;
            ramReq.writeEnable = dataReq.writeEnable;
            ramReq.address     = dataReq.address;
            ramReq.storeWord   = dataReq.storeWord;
         end
         GRANT_INSTR: begin
            // fetch never writes
            ramReq.readEnable = 1'b1;
            ramReq.address    = instrReq.address;
         end
         default: begin
            ramReq = '0;
         end
      endcase
   end

   // port waits and loads
   always_comb begin
      // both loads see the RAM word
      instrResp.loadWord = ramLoad;
      dataResp.loadWord  = ramLoad;
      instrResp.waitFlag = 1'b0;
      dataResp.waitFlag  = 1'b0;
      case (grant)
         GRANT_DATA: begin
            // fetch stalls behind the data access
            instrResp.waitFlag = 1'b1;
            dataResp.waitFlag  = !ramReady;
         end
         GRANT_INSTR: begin
            instrResp.waitFlag = !ramReady;
         end
         default: begin
            instrResp.waitFlag = 1'b0;
            dataResp.waitFlag  = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/ramBank.sv
/*
 * Slow single-port word RAM.
 * FREE/BUSY/ACCESS state machine with a latency counter.
 * Reads show and writes commit in the single ACCESS cycle.
 */
`default_nettype none

module ramBank (
   input  logic                     CLK,
   input  logic                     reset,
   input  cpuTypesPkg::ramRequest   ramReq,
   output cpuTypesPkg::ramStateType ramState,
   output cpuTypesPkg::word         ramLoad
);
   import cpuTypesPkg::*;
   import memConfigPkg::*;

   // word storage
   word memory [RAM_DEPTH];

   // fsm state and count of busy cycles spent
   ramStateType                state;
   logic [RAM_COUNT_WIDTH-1:0] busyCount;

   // request from the previous cycle
   ramRequest lastReq;

   logic                       requestActive;
   logic                       requestChanged;
   logic                       accessValid;
   logic [RAM_INDEX_WIDTH-1:0] ramIndex;

   assign requestActive = ramReq.readEnable | ramReq.writeEnable;

   // any difference from last cycle means a new request
   // e.g. data preempting a fetch
   assign requestChanged = (ramReq != lastReq);

   // addresses wrap to the bank depth
   assign ramIndex = ramReq.address[RAM_INDEX_WIDTH-1:0];

   // access cycle belongs to the request that was counted
   assign accessValid = (state == ACCESS) && !requestChanged;

   // latency state machine
   always_ff @(posedge CLK) begin
      if (reset) begin
         state     <= FREE;
         busyCount <= '0;
      end else begin
         case (state)
            FREE: begin
               // sampled request starts the busy phase
               if (requestActive) begin
                  state     <= BUSY;
                  busyCount <= RAM_COUNT_WIDTH'(1);
               end
            end
            BUSY: begin
               if (!requestActive) begin
                  // request withdrawn
                  state <= FREE;
               end else if (requestChanged) begin
                  // new request, count again from the start
                  busyCount <= RAM_COUNT_WIDTH'(1);
               end else if (busyCount == RAM_COUNT_WIDTH'(RAM_LATENCY)) begin
                  state <= ACCESS;
               end else begin
                  busyCount <= busyCount + 1'b1;
               end
            end
            ACCESS: begin
               // one access cycle, then at least one free cycle
               state <= FREE;
            end
            default: begin
               state <= FREE;
            end
         endcase
      end
   end

   // previous request for change detection
   always_ff @(posedge CLK) begin
      lastReq <= ramReq;
   end

   // storage, cleared on reset
   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < RAM_DEPTH; i++) begin
            memory[i] <= '0;
         end
      end else if (accessValid && ramReq.writeEnable) begin
         // write lands at the end of the access cycle
         memory[ramIndex] <= ramReq.storeWord;
      end
   end

   // read word only valid during the access cycle
   assign ramLoad = accessValid ? memory[ramIndex] : '0;

   // a request swapped in during ACCESS has not been served yet
   // so it still reads as busy
   assign ramState = ((state == ACCESS) && requestChanged) ? BUSY : state;

endmodule

`default_nettype wire

//--- rtl/memorySystem.sv
/*
 * Memory system top level.
 * Memory controller in front of the slow word RAM bank.
 */
`default_nettype none

module memorySystem (
   input  logic                     CLK,
   input  logic                     reset,
   input  cpuTypesPkg::instrRequest instrReq,
   input  cpuTypesPkg::dataRequest  dataReq,
   output cpuTypesPkg::portResponse instrResp,
   output cpuTypesPkg::portResponse dataResp
);
   import cpuTypesPkg::*;

   // controller to RAM
   ramRequest   ramReq;

   // RAM back to controller
   ramStateType ramState;
   word         ramLoad;

   // arbiter, purely combinational
   memoryControl i_memoryControl (
      .instrReq  (instrReq),
      .dataReq   (dataReq),
      .ramState  (ramState),
      .ramLoad   (ramLoad),
      .ramReq    (ramReq),
      .instrResp (instrResp),
      .dataResp  (dataResp)
   );

   // slow RAM with fixed latency
   ramBank i_ramBank (
      .CLK      (CLK),
      .reset    (reset),
      .ramReq   (ramReq),
      .ramState (ramState),
      .ramLoad  (ramLoad)
   );

endmodule

`default_nettype wire

//--- test/memorySystemTb.sv
/*
 * Testbench for the memory system.
 * Random fetch, data read, data write and preempting traffic from a fixed seed,
 * checked against a shadow memory, with latency and priority checks.
 */
`default_nettype none

module memorySystemTb;
   import cpuTypesPkg::*;
   import memConfigPkg::*;

   // run length and cycle budget
   localparam int NUM_OPS        = 200;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 4 * (RAM_LATENCY + 3);
   // edges from first presentation to wait low
   localparam int EXPECTED_EDGES = RAM_LATENCY + 1;

   logic        CLK;
   logic        reset;
   instrRequest instrReq;
   dataRequest  dataReq;
   portResponse instrResp;
   portResponse dataResp;

   // shadow of the RAM contents
   word model [RAM_DEPTH];

   integer seed;
   int     loadErrors;
   int     waitErrors;
   int     latencyErrors;
   int     cycleCount = 0;

   memorySystem i_memorySystem (
      .CLK       (CLK),
      .reset     (reset),
      .instrReq  (instrReq),
      .dataReq   (dataReq),
      .instrResp (instrResp),
      .dataResp  (dataResp)
   );

   // 20 unit clock
   always #10 CLK = ~CLK;

   // run limit
   always @(posedge CLK) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > TIMEOUT_CYCLES) begin
         $display("timeout: requests did not complete");
         reportCounts();
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic reportCounts;
      $display("errors: load %0d, wait %0d, latency %0d", loadErrors, waitErrors,
               latencyErrors);
   endtask

   // low index bits, address wraps to the depth
   function automatic int unsigned wrapIndex(input wordAddress address);
      return address % RAM_DEPTH;
   endfunction

   // mix of plain, hot, aliased hot and full-range addresses
   function automatic wordAddress randomAddress();
      int unsigned pick;
      wordAddress  address;
      pick = $unsigned($random(seed)) % 4;
      case (pick)
         0: address = $unsigned($random(seed)) % RAM_DEPTH;
         1: address = $unsigned($random(seed)) % 8;
         2: begin
            // hot word seen through a wrapped alias
            address = $unsigned($random(seed)) % 8;
            address = address + RAM_DEPTH * ($unsigned($random(seed)) % 16);
         end
         default: address = $random(seed);
      endcase
      return address;
   endfunction

   task automatic driveFetch(input wordAddress address);
      instrReq.readEnable <= 1'b1;
      instrReq.address    <= address;
   endtask

   task automatic driveData(input logic isWrite, input wordAddress address,
                            input word storeWord);
      dataReq.readEnable  <= !isWrite;
      dataReq.writeEnable <= isWrite;
      dataReq.address     <= address;
      dataReq.storeWord   <= storeWord;
   endtask

   task automatic clearFetch;
      instrReq <= '0;
   endtask

   task automatic clearData;
      dataReq <= '0;
   endtask

   task automatic expectWait(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %b got %b", $time, name, expected, actual);
         waitErrors++;
      end
   endtask

   task automatic checkWord(input string name, input word expected, input word actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
         loadErrors++;
      end
   endtask

   task automatic checkLatency(input string name, input int edges);
      if (edges != EXPECTED_EDGES) begin
         $display("Fail at %0t: latency of %s expected %0d got %0d", $time, name,
                  EXPECTED_EDGES, edges);
         latencyErrors++;
      end
   endtask

   // data port pending, fetch must stall the whole time
   task automatic waitData(output int edges);
      edges = 0;
      @(negedge CLK);
      while (dataResp.waitFlag !== 1'b0) begin
         expectWait("instrResp.waitFlag", 1'b1, instrResp.waitFlag);
         @(posedge CLK);
         edges++;
         @(negedge CLK);
      end
      // still stalled in the access cycle
      expectWait("instrResp.waitFlag", 1'b1, instrResp.waitFlag);
   endtask

   // only a fetch pending, data wait stays low
   task automatic waitFetch(output int edges);
      edges = 0;
      @(negedge CLK);
      while (instrResp.waitFlag !== 1'b0) begin
         expectWait("dataResp.waitFlag", 1'b0, dataResp.waitFlag);
         @(posedge CLK);
         edges++;
         @(negedge CLK);
      end
      expectWait("dataResp.waitFlag", 1'b0, dataResp.waitFlag);
   endtask

   task automatic fetchOnly;
      wordAddress address;
      int         edges;
      address = randomAddress();
      @(posedge CLK);
      driveFetch(address);
      clearData();
      waitFetch(edges);
      checkLatency("instrResp.waitFlag", edges);
      checkWord("instrResp.loadWord", model[wrapIndex(address)], instrResp.loadWord);
   endtask

   task automatic dataOnly(input logic isWrite);
      wordAddress address;
      word        storeWord;
      int         edges;
      address   = randomAddress();
      storeWord = $random(seed);
      @(posedge CLK);
      clearFetch();
      driveData(isWrite, address, storeWord);
      waitData(edges);
      checkLatency("dataResp.waitFlag", edges);
      if (isWrite) begin
         // commits at the edge that ends the access
         model[wrapIndex(address)] = storeWord;
      end else begin
         checkWord("dataResp.loadWord", model[wrapIndex(address)], dataResp.loadWord);
      end
   endtask

   // fetch waiting, then a data access takes the RAM
   task automatic preemptedFetch;
      wordAddress fetchAddress;
      wordAddress dataAddress;
      word        storeWord;
      logic       isWrite;
      int         delay;
      int         edges;
      fetchAddress = randomAddress();
      // half the time same word, so the fetch must see the write
      if (($unsigned($random(seed)) % 2) == 1) begin
         dataAddress = fetchAddress;
      end else begin
         dataAddress = randomAddress();
      end
      isWrite   = ($unsigned($random(seed)) % 2) == 1;
      storeWord = $random(seed);
      // up to the edge where the fetch would enter access
      delay     = $unsigned($random(seed)) % (RAM_LATENCY + 2);
      @(posedge CLK);
      driveFetch(fetchAddress);
      clearData();
      // fetch alone for a while, never long enough to finish
      repeat (delay) begin
         @(negedge CLK);
         expectWait("instrResp.waitFlag", 1'b1, instrResp.waitFlag);
         expectWait("dataResp.waitFlag", 1'b0, dataResp.waitFlag);
         @(posedge CLK);
      end
      driveData(isWrite, dataAddress, storeWord);
      waitData(edges);
      if (isWrite) begin
         model[wrapIndex(dataAddress)] = storeWord;
      end else begin
         checkWord("dataResp.loadWord", model[wrapIndex(dataAddress)], dataResp.loadWord);
      end
      // data done, fetch held and restarts
      @(posedge CLK);
      clearData();
      waitFetch(edges);
      checkWord("instrResp.loadWord", model[wrapIndex(fetchAddress)], instrResp.loadWord);
   endtask

   task automatic idleCycle;
      @(posedge CLK);
      clearFetch();
      clearData();
      @(negedge CLK);
      expectWait("instrResp.waitFlag", 1'b0, instrResp.waitFlag);
      expectWait("dataResp.waitFlag", 1'b0, dataResp.waitFlag);
   endtask

   initial begin
      int op;
      CLK           = 1'b0;
      reset         = 1'b1;
      instrReq      = '0;
      dataReq       = '0;
      seed          = 87;
      loadErrors    = 0;
      waitErrors    = 0;
      latencyErrors = 0;
      // RAM clears on reset
      for (int i = 0; i < RAM_DEPTH; i++) begin
         model[i] = '0;
      end
      repeat (10) @(posedge CLK);
      reset <= 1'b0;
      // quiet ports after reset
      @(negedge CLK);
      expectWait("instrResp.waitFlag", 1'b0, instrResp.waitFlag);
      expectWait("dataResp.waitFlag", 1'b0, dataResp.waitFlag);
      for (int n = 0; n < NUM_OPS; n++) begin
         op = $unsigned($random(seed)) % 4;
         case (op)
            0: fetchOnly();
            1: dataOnly(1'b0);
            2: dataOnly(1'b1);
            default: preemptedFetch();
         endcase
         if (($unsigned($random(seed)) % 4) == 0) begin
            idleCycle();
         end
      end
      idleCycle();
      reportCounts();
      if (loadErrors + waitErrors + latencyErrors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
rtl/cpuTypesPkg.sv
rtl/memConfigPkg.sv
rtl/memoryControl.sv
rtl/ramBank.sv
rtl/memorySystem.sv
test/memorySystemTb.sv

//--- Bender.yml
package:
  name: memory_system

sources:
  # packages first, then the RTL that imports them
  - files:
      - rtl/cpuTypesPkg.sv
      - rtl/memConfigPkg.sv
      - rtl/memoryControl.sv
      - rtl/ramBank.sv
      - rtl/memorySystem.sv

  # testbench
  - target: test
    files:
      - test/memorySystemTb.sv
